// ==== src/simt_pkg.sv ====
package simt_pkg;

    // Core dimensions
    localparam int NUM_LANES = 8;
    localparam int DATA_WIDTH = 32;
    localparam int NUM_REGS = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int LANE_ID_REG = 31;
    localparam int LANE_IDX_WIDTH = $clog2(NUM_LANES);
    localparam int IMEM_ADDR_WIDTH = 10;

    // Instruction word layout
    localparam int OPCODE_WIDTH = 5;
    localparam int OPCODE_LSB = 27;
    localparam int RD_LSB = 22;
    localparam int RS1_LSB = 17;
    localparam int RS2_LSB = 12;
    localparam int IMM_WIDTH = 12;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [IMEM_ADDR_WIDTH-1:0] imem_addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [NUM_LANES-1:0] lane_mask_t;

    // Scalar ops in the low half, vector ops from 5'h10
    typedef enum logic [OPCODE_WIDTH-1:0] {
        ADDI  = 5'h01,
        ADD   = 5'h02,
        SUB   = 5'h03,
        AND   = 5'h04,
        OR    = 5'h05,
        XOR   = 5'h06,
        SLT   = 5'h07,
        BNEZ  = 5'h08,
        OUT   = 5'h09,
        HALT  = 5'h0a,
        VADD  = 5'h10,
        VSUB  = 5'h11,
        VADDI = 5'h12,
        VADDS = 5'h13,
        VSLT  = 5'h14,
        VEXT  = 5'h15
    } opcode_t;

    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        data_t     imm;
        logic      is_vector;
        logic      exec;
    } decoded_t;

    typedef struct packed {
        data_t alu_value;
        data_t rs1_value;
        logic  branch_taken;
    } scalar_result_t;

    // VSLT mask zero-extended, or the selected lane for VEXT
    typedef struct packed {
        data_t reduce_value;
    } vector_result_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        data_t     value;
    } writeback_t;

    typedef enum logic [2:0] {
        FETCH,
        EXECUTE,
        OUTPUT,
        DONE,
        IDLE
    } seq_state_t;

endpackage

// ==== src/warp_sequencer.sv ====
`timescale 1ns/10ps

module warp_sequencer
    import simt_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           start,

    output logic           imem_req,
    input  logic           imem_ack,
    output imem_addr_t     imem_addr,
    input  instr_t         imem_data,

    output logic           out_req,
    output data_t          out_data,
    input  logic           out_ack,

    output logic           done,

    output decoded_t       decoded,
    input  scalar_result_t scalar_result,
    input  vector_result_t vector_result,
    output writeback_t     writeback
);

    seq_state_t state;
    imem_addr_t pc;
    imem_addr_t next_pc;
    instr_t     instr_reg;
    logic       is_reduce;

    // Field decode of the held instruction
    always_comb begin
        decoded.opcode = opcode_t'(instr_reg[OPCODE_LSB +: OPCODE_WIDTH]);
        decoded.rd = instr_reg[RD_LSB +: REG_ADDR_WIDTH];
        decoded.rs1 = instr_reg[RS1_LSB +: REG_ADDR_WIDTH];
        decoded.rs2 = instr_reg[RS2_LSB +: REG_ADDR_WIDTH];
        decoded.imm = {{(DATA_WIDTH-IMM_WIDTH){instr_reg[IMM_WIDTH-1]}},
                       instr_reg[IMM_WIDTH-1:0]};
        decoded.is_vector = decoded.opcode inside {VADD, VSUB, VADDI, VADDS, VSLT, VEXT};
        decoded.exec = (state == EXECUTE);
    end

    // Reductions land in the scalar file instead of the ALU value
    assign is_reduce = decoded.opcode inside {VSLT, VEXT};

    always_comb begin
        writeback.we = decoded.exec &&
            (decoded.opcode inside {ADDI, ADD, SUB, AND, OR, XOR, SLT, VSLT, VEXT});
        writeback.rd = decoded.rd;
        writeback.value = is_reduce ? vector_result.reduce_value : scalar_result.alu_value;
    end

    // Branch offset wraps within the instruction space
    assign next_pc = scalar_result.branch_taken ?
                     pc + decoded.imm[IMEM_ADDR_WIDTH-1:0] :
                     pc + imem_addr_t'(1);

    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            pc <= '0;
            imem_req <= 1'b0;
            out_req <= 1'b0;
            done <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= FETCH;
                        imem_req <= 1'b1;
                    end
                end
                FETCH: begin
                    // Capture on ack, then wait for ack to fall
                    if (imem_req && imem_ack) begin
                        imem_req <= 1'b0;
                    end else if (!imem_req && !imem_ack) begin
                        state <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    pc <= next_pc;
                    if (decoded.opcode == HALT) begin
                        state <= DONE;
                        done <= 1'b1;
                    end else if (decoded.opcode == OUT) begin
                        state <= OUTPUT;
                        out_req <= 1'b1;
                    end else begin
                        state <= FETCH;
                        imem_req <= 1'b1;
                    end
                end
                OUTPUT: begin
                    if (out_req && out_ack) begin
                        out_req <= 1'b0;
                    end else if (!out_req && !out_ack) begin
                        state <= FETCH;
                        imem_req <= 1'b1;
                    end
                end
                default: begin
                    // Halted until reset
                    state <= DONE;
                end
            endcase
        end
    end

    // Instruction and output payload
    always_ff @(posedge clk) begin
        if (state == FETCH && imem_req && imem_ack) begin
            instr_reg <= imem_data;
        end
        if (decoded.exec && decoded.opcode == OUT) begin
            out_data <= scalar_result.rs1_value;
        end
    end

endmodule

// ==== src/scalar_unit.sv ====
`timescale 1ns/10ps

module scalar_unit
    import simt_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  decoded_t       decoded,
    input  writeback_t     writeback,
    output scalar_result_t scalar_result,
    output data_t          scalar_rs2
);

    data_t regs [NUM_REGS];
    data_t rs1_val;
    data_t rs2_val;
    data_t alu_value;

    // Register 0 is hardwired to zero
    assign rs1_val = (decoded.rs1 == '0) ? '0 : regs[decoded.rs1];
    assign rs2_val = (decoded.rs2 == '0) ? '0 : regs[decoded.rs2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeback.we && writeback.rd != '0) begin
            regs[writeback.rd] <= writeback.value;
        end
    end

    always_comb begin
        case (decoded.opcode)
            ADDI: alu_value = rs1_val + decoded.imm;
            ADD: alu_value = rs1_val + rs2_val;
            SUB: alu_value = rs1_val - rs2_val;
            AND: alu_value = rs1_val & rs2_val;
            OR: alu_value = rs1_val | rs2_val;
            XOR: alu_value = rs1_val ^ rs2_val;
            SLT: alu_value = data_t'($signed(rs1_val) < $signed(rs2_val));
            default: alu_value = '0;
        endcase
    end

    always_comb begin
        scalar_result.alu_value = alu_value;
        scalar_result.rs1_value = rs1_val;
        // Taken when the tested register is nonzero
        scalar_result.branch_taken = (decoded.opcode == BNEZ) && (rs1_val != '0);
    end

    // Broadcast operand for VADDS
    assign scalar_rs2 = rs2_val;

endmodule

// ==== src/vector_unit.sv ====
`timescale 1ns/10ps

module vector_unit
    import simt_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  decoded_t       decoded,
    input  data_t          scalar_rs2,
    output vector_result_t vector_result
);

    data_t      lane_rs1 [NUM_LANES];
    lane_mask_t lt_mask;

    for (genvar lane = 0; lane < NUM_LANES; lane++) begin : g_lane
        data_t vregs [NUM_REGS];
        data_t op_a;
        data_t op_b;
        data_t result;
        logic  lane_we;

        // Register 31 reads back this lane's index
        assign op_a = (decoded.rs1 == reg_addr_t'(LANE_ID_REG)) ?
                      data_t'(lane) : vregs[decoded.rs1];
        assign op_b = (decoded.rs2 == reg_addr_t'(LANE_ID_REG)) ?
                      data_t'(lane) : vregs[decoded.rs2];

        always_comb begin
            lane_we = decoded.exec && decoded.is_vector;
            case (decoded.opcode)
                VADD: result = op_a + op_b;
                VSUB: result = op_a - op_b;
                VADDI: result = op_a + decoded.imm;
                VADDS: result = op_a + scalar_rs2;
                default: begin
                    // VSLT and VEXT only feed the reduction
                    result = '0;
                    lane_we = 1'b0;
                end
            endcase
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                for (int i = 0; i < NUM_REGS; i++) begin
                    vregs[i] <= '0;
                end
            end else if (lane_we && decoded.rd != reg_addr_t'(LANE_ID_REG)) begin
                vregs[decoded.rd] <= result;
            end
        end

        assign lane_rs1[lane] = op_a;
        assign lt_mask[lane] = $signed(op_a) < $signed(op_b);
    end

    // Mask for VSLT, otherwise the lane picked by imm mod 8
    always_comb begin
        if (decoded.opcode == VSLT) begin
            vector_result.reduce_value = data_t'(lt_mask);
        end else begin
            vector_result.reduce_value = lane_rs1[decoded.imm[LANE_IDX_WIDTH-1:0]];
        end
    end

endmodule

// ==== src/simt_core.sv ====
`timescale 1ns/10ps

module simt_core
    import simt_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,

    output logic       imem_req,
    input  logic       imem_ack,
    output imem_addr_t imem_addr,
    input  instr_t     imem_data,

    output logic       out_req,
    output data_t      out_data,
    input  logic       out_ack,

    output logic       done
);

    decoded_t       decoded;
    writeback_t     writeback;
    scalar_result_t scalar_result;
    vector_result_t vector_result;
    data_t          scalar_rs2;

    // Fetch, decode and result combining
    warp_sequencer u_warp_sequencer (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .imem_req      (imem_req),
        .imem_ack      (imem_ack),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .out_req       (out_req),
        .out_data      (out_data),
        .out_ack       (out_ack),
        .done          (done),
        .decoded       (decoded),
        .scalar_result (scalar_result),
        .vector_result (vector_result),
        .writeback     (writeback)
    );

    scalar_unit u_scalar_unit (
        .clk           (clk),
        .reset         (reset),
        .decoded       (decoded),
        .writeback     (writeback),
        .scalar_result (scalar_result),
        .scalar_rs2    (scalar_rs2)
    );

    // Eight lanes in lockstep
    vector_unit u_vector_unit (
        .clk           (clk),
        .reset         (reset),
        .decoded       (decoded),
        .scalar_rs2    (scalar_rs2),
        .vector_result (vector_result)
    );

endmodule

// ==== bench/simt_core_asserts.sv ====
`timescale 1ns/10ps

module simt_core_asserts (
    input logic clk,
    input logic reset,
    input logic imem_req,
    input logic imem_ack,
    input logic out_req,
    input logic out_ack,
    input logic done
);

    // Requests stay up until the other side acknowledges
    a_imem_req_held: assert property (@(posedge clk) disable iff (reset)
        imem_req && !imem_ack |=> imem_req)
        else $error("imem_req dropped before imem_ack");

    a_out_req_held: assert property (@(posedge clk) disable iff (reset)
        out_req && !out_ack |=> out_req)
        else $error("out_req dropped before out_ack");

    // No new request while the previous ack is still high
    a_imem_req_rise: assert property (@(posedge clk) disable iff (reset)
        !imem_req && imem_ack |=> !imem_req)
        else $error("imem_req rose while imem_ack was high");

    a_out_req_rise: assert property (@(posedge clk) disable iff (reset)
        !out_req && out_ack |=> !out_req)
        else $error("out_req rose while out_ack was high");

    a_done_sticky: assert property (@(posedge clk) disable iff (reset)
        done |=> done)
        else $error("done fell without reset");

endmodule

bind simt_core simt_core_asserts u_asserts (
    .clk      (clk),
    .reset    (reset),
    .imem_req (imem_req),
    .imem_ack (imem_ack),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .done     (done)
);

// ==== bench/simt_core_tb.sv ====
`timescale 1ns/10ps

module simt_core_tb
    import simt_pkg::*;
();

    localparam string STIM_FILE = "bench/program_stimulus.txt";
    localparam int STIM_DEPTH = 64;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int HANDSHAKE_TIMEOUT = 50;
    localparam int QUIET_CYCLES = 40;

    logic       clk;
    logic       reset;
    logic       start;
    logic       imem_req;
    logic       imem_ack;
    imem_addr_t imem_addr;
    instr_t     imem_data;
    logic       out_req;
    data_t      out_data;
    logic       out_ack;
    logic       done;

    logic [31:0] stim [STIM_DEPTH];
    int prog_count;
    int expected_count;
    int out_count = 0;
    int fetch_count = 0;
    imem_addr_t last_fetch_addr;
    int errors = 0;
    int timeouts = 0;
    int seed = 96814;

    simt_core DUT (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .imem_req  (imem_req),
        .imem_ack  (imem_ack),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .out_req   (out_req),
        .out_data  (out_data),
        .out_ack   (out_ack),
        .done      (done)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input imem_addr_t expected,
                              input imem_addr_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    // Program words start at index 1, expected outputs follow their count
    task automatic load_stimulus();
        $readmemh(STIM_FILE, stim);
        if ($isunknown(stim[0])) begin
            $display("Stimulus file %s could not be read", STIM_FILE);
            errors++;
            prog_count = 0;
            expected_count = 0;
        end else begin
            prog_count = int'(stim[0]);
            expected_count = int'(stim[prog_count + 1]);
        end
    endtask

    task automatic finish_run();
        $display("Run complete: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    // Instruction memory with a random 0 to 3 cycle ack delay
    initial begin : imem_model
        int delay;
        int cycles;
        forever begin
            @(posedge clk);
            if (!reset && imem_req && !imem_ack) begin
                delay = $random(seed) & 3;
                repeat (delay) @(posedge clk);
                // Execution starts from address 0 after reset
                if (fetch_count == 0) begin
                    check_addr("first fetch address", imem_addr_t'(0), imem_addr);
                end
                last_fetch_addr = imem_addr;
                fetch_count++;
                if (int'(imem_addr) < prog_count) begin
                    imem_data <= stim[1 + int'(imem_addr)];
                end else begin
                    $display("Fetch from address %0d is past the end of the program", imem_addr);
                    errors++;
                    imem_data <= instr_t'({HALT, 27'd0});
                end
                imem_ack <= 1'b1;
                cycles = 0;
                do begin
                    @(posedge clk);
                    cycles++;
                end while (imem_req && cycles < HANDSHAKE_TIMEOUT);
                if (imem_req) begin
                    $display("Timeout: imem_req stayed high after imem_ack");
                    timeouts++;
                end
                imem_ack <= 1'b0;
            end
        end
    end

    // Output receiver that checks each value against the expected list
    initial begin : out_model
        int delay;
        int cycles;
        forever begin
            @(posedge clk);
            if (!reset && out_req && !out_ack) begin
                delay = $random(seed) & 3;
                repeat (delay) @(posedge clk);
                if (out_count < expected_count) begin
                    check_data($sformatf("output %0d", out_count),
                               stim[prog_count + 2 + out_count], out_data);
                end else begin
                    $display("Unexpected extra output with value %h", out_data);
                    errors++;
                end
                out_count++;
                out_ack <= 1'b1;
                cycles = 0;
                do begin
                    @(posedge clk);
                    cycles++;
                end while (out_req && cycles < HANDSHAKE_TIMEOUT);
                if (out_req) begin
                    $display("Timeout: out_req stayed high after out_ack");
                    timeouts++;
                end
                out_ack <= 1'b0;
            end
        end
    end

    initial begin : main_sequence
        int cycles;
        logic late_fetch;
        reset <= 1'b1;
        start <= 1'b0;
        imem_ack <= 1'b0;
        imem_data <= '0;
        out_ack <= 1'b0;
        load_stimulus();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;

        cycles = 0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("Timeout: done did not rise within %0d cycles", TIMEOUT_CYCLES);
            timeouts++;
        end
        check_flag("done after halt", 1'b1, done);

        // A halted core must not fetch again
        late_fetch = 1'b0;
        cycles = 0;
        while (cycles < QUIET_CYCLES) begin
            @(posedge clk);
            if (imem_req) begin
                late_fetch = 1'b1;
            end
            cycles++;
        end
        check_flag("no fetch after halt", 1'b0, late_fetch);
        check_data("output count", data_t'(expected_count), data_t'(out_count));
        // Halt is the last program word
        check_addr("halt fetch address", imem_addr_t'(prog_count - 1), last_fetch_addr);
        finish_run();
    end

endmodule

// ==== sim.f ====
src/simt_pkg.sv
src/warp_sequencer.sv
src/scalar_unit.sv
src/vector_unit.sv
src/simt_core.sv
bench/simt_core_asserts.sv
bench/simt_core_tb.sv

// ==== Makefile ====
TOP = simt_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// ==== bench/program_stimulus.txt ====
// One hex word per line: program word count, program words,
// then expected output count and the expected OUT values in order
0000001f
08400064  // addi r1, r0, 100
08800ffd  // addi r2, r0, -3
10c22000  // add r3, r1, r2
48060000  // out r3
21422000  // and r5, r1, r2
314a3000  // xor r5, r5, r3
294a1000  // or r5, r5, r1
480a0000  // out r5
39841000  // slt r6, r2, r1
39c22000  // slt r7, r1, r2
198e6000  // sub r6, r7, r6
480c0000  // out r6
907e0005  // vaddi v1, v31, 5
98821000  // vadds v2, v1, s1
80c41000  // vadd v3, v2, v1
8907f000  // vsub v4, v3, v31
aa080003  // vext s8, v4, lane 3
48100000  // out s8
aa46000d  // vext s9, v3, 13 selects lane 5
48120000  // out s9
0a800005  // addi s10, r0, 5
9940a000  // vadds v5, v0, s10
a2fe5000  // vslt s11, v31, v5
48160000  // out s11
0b000004  // addi s12, r0, 4
0b400000  // addi s13, r0, 0
135ac000  // loop: add s13, s13, s12
0b180fff  // addi s12, s12, -1
40180ffe  // bnez s12, -2
481a0000  // out s13
50000000  // halt
00000007
00000061  // 100 + -3
00000065  // (100 & -3) ^ 97 | 100
ffffffff  // 0 - 1 wraps
00000071  // lane 3 of v4
00000078  // lane 5 of v3
0000001f  // lanes 0 to 4 below 5
0000000a  // 4 + 3 + 2 + 1
